// File: rtl/alu_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module alu_pipe #(
  parameter int unsigned XLEN = 32,
  parameter int unsigned ROB_DEPTH = 8
) (
  input  logic                         clock,
  input  logic                         arst_n_i,
  input  logic                         flush_i,
  input  logic                         issue_valid_i,
  input  issue_pkg::opcode_e           issue_op_i,
  input  logic [XLEN-1:0]              issue_a_i,
  input  logic [XLEN-1:0]              issue_b_i,
  input  logic [XLEN-1:0]              issue_imm_i,
  input  logic [XLEN-1:0]              issue_pc_i,
  input  logic [XLEN-1:0]              issue_pnpc_i,
  input  logic [$clog2(ROB_DEPTH)-1:0] issue_tag_i,
  output logic                         wb_valid_o,
  output logic [$clog2(ROB_DEPTH)-1:0] wb_tag_o,
  output logic [XLEN-1:0]              wb_value_o,
  output logic [XLEN-1:0]              wb_npc_o
);
  localparam int unsigned TAG_W = $clog2(ROB_DEPTH);

  logic [XLEN-1:0]  seq_pc;
  logic [XLEN-1:0]  calc_npc;
  logic [XLEN-1:0]  alu_value;
  logic             taken;
  logic             s1_valid;
  logic [TAG_W-1:0] s1_tag;
  logic [XLEN-1:0]  s1_value;
  logic [XLEN-1:0]  s1_npc;

  always_comb begin
    seq_pc    = issue_pc_i + XLEN'(issue_pkg::PC_STEP);
    taken     = 1'b0;
    alu_value = '0;
    unique case (issue_op_i)
      issue_pkg::OP_ADD:  alu_value = issue_a_i + issue_b_i;
      issue_pkg::OP_SUB:  alu_value = issue_a_i - issue_b_i;
      issue_pkg::OP_AND:  alu_value = issue_a_i & issue_b_i;
      issue_pkg::OP_OR:   alu_value = issue_a_i | issue_b_i;
      issue_pkg::OP_XOR:  alu_value = issue_a_i ^ issue_b_i;
      issue_pkg::OP_ADDI: alu_value = issue_a_i + issue_imm_i;
      issue_pkg::OP_BEQ:  taken = issue_a_i == issue_b_i;
      issue_pkg::OP_BNE:  taken = issue_a_i != issue_b_i;
      default:            alu_value = '0;
    endcase
    calc_npc = taken ? issue_pc_i + issue_imm_i : seq_pc;
  end

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_valid   <= 1'b0;
      wb_valid_o <= 1'b0;
    end else if (flush_i) begin
      s1_valid   <= 1'b0;
      wb_valid_o <= 1'b0;
    end else begin
      s1_valid   <= issue_valid_i;
      wb_valid_o <= s1_valid;
    end
  end

  // stage one result, then the writeback register
  always_ff @(posedge clock) begin
    s1_tag     <= issue_tag_i;
    s1_value   <= alu_value;
    s1_npc     <= calc_npc;
    wb_tag_o   <= s1_tag;
    wb_value_o <= s1_value;
    wb_npc_o   <= s1_npc;
  end

endmodule

`default_nettype wire

// File: rtl/issue_core.sv
`timescale 1ns/100ps
`default_nettype none

module issue_core #(
  parameter int unsigned XLEN = 32,
  parameter int unsigned UOQ_DEPTH = 4,
  parameter int unsigned ROB_DEPTH = 8
) (
  input  logic                        clock,
  input  logic                        arst_n_i,
  input  logic                        uop_valid_i,
  input  issue_pkg::opcode_e          uop_op_i,
  input  logic [issue_pkg::REG_W-1:0] uop_rd_i,
  input  logic [issue_pkg::REG_W-1:0] uop_rs1_i,
  input  logic [issue_pkg::REG_W-1:0] uop_rs2_i,
  input  logic [XLEN-1:0]             uop_imm_i,
  input  logic [XLEN-1:0]             uop_pc_i,
  input  logic [XLEN-1:0]             uop_pnpc_i,
  output logic                        uop_ready_o,
  output logic                        commit_valid_o,
  output logic [issue_pkg::REG_W-1:0] commit_rd_o,
  output logic [XLEN-1:0]             commit_value_o,
  output logic [XLEN-1:0]             commit_pc_o,
  output logic                        flush_o,
  output logic [XLEN-1:0]             redirect_pc_o
);
  localparam int unsigned TAG_W = $clog2(ROB_DEPTH);

  logic                        uoq_full;
  logic                        head_valid;
  issue_pkg::opcode_e          head_op;
  logic [issue_pkg::REG_W-1:0] head_rd;
  logic [issue_pkg::REG_W-1:0] head_rs1;
  logic [issue_pkg::REG_W-1:0] head_rs2;
  logic [XLEN-1:0]             head_imm;
  logic [XLEN-1:0]             head_pc;
  logic [XLEN-1:0]             head_pnpc;
  logic                        dispatch;
  logic [XLEN-1:0]             rdata1;
  logic [XLEN-1:0]             rdata2;
  logic                        issue_valid;
  issue_pkg::opcode_e          issue_op;
  logic [XLEN-1:0]             issue_a;
  logic [XLEN-1:0]             issue_b;
  logic [XLEN-1:0]             issue_imm;
  logic [XLEN-1:0]             issue_pc;
  logic [XLEN-1:0]             issue_pnpc;
  logic [TAG_W-1:0]            issue_tag;
  logic                        wb_valid;
  logic [TAG_W-1:0]            wb_tag;
  logic [XLEN-1:0]             wb_value;
  logic [XLEN-1:0]             wb_npc;

  assign uop_ready_o = !uoq_full;

  uop_queue #(.XLEN(XLEN), .UOQ_DEPTH(UOQ_DEPTH)) u_queue (
    .clock, .arst_n_i,
    .flush_i(flush_o), .push_i(uop_valid_i),
    .push_op_i(uop_op_i), .push_rd_i(uop_rd_i),
    .push_rs1_i(uop_rs1_i), .push_rs2_i(uop_rs2_i),
    .push_imm_i(uop_imm_i), .push_pc_i(uop_pc_i), .push_pnpc_i(uop_pnpc_i),
    .pop_i(dispatch), .full_o(uoq_full), .head_valid_o(head_valid),
    .head_op_o(head_op), .head_rd_o(head_rd),
    .head_rs1_o(head_rs1), .head_rs2_o(head_rs2),
    .head_imm_o(head_imm), .head_pc_o(head_pc), .head_pnpc_o(head_pnpc)
  );

  reorder_buffer #(.XLEN(XLEN), .ROB_DEPTH(ROB_DEPTH)) u_rob (
    .clock, .arst_n_i,
    .head_valid_i(head_valid), .head_op_i(head_op), .head_rd_i(head_rd),
    .head_rs1_i(head_rs1), .head_rs2_i(head_rs2), .head_imm_i(head_imm),
    .head_pc_i(head_pc), .head_pnpc_i(head_pnpc), .dispatch_o(dispatch),
    .rdata1_i(rdata1), .rdata2_i(rdata2),
    .issue_valid_o(issue_valid), .issue_op_o(issue_op),
    .issue_a_o(issue_a), .issue_b_o(issue_b), .issue_imm_o(issue_imm),
    .issue_pc_o(issue_pc), .issue_pnpc_o(issue_pnpc), .issue_tag_o(issue_tag),
    .wb_valid_i(wb_valid), .wb_tag_i(wb_tag),
    .wb_value_i(wb_value), .wb_npc_i(wb_npc),
    .commit_valid_o, .commit_rd_o, .commit_value_o, .commit_pc_o,
    .flush_o, .redirect_pc_o
  );

  alu_pipe #(.XLEN(XLEN), .ROB_DEPTH(ROB_DEPTH)) u_alu (
    .clock, .arst_n_i, .flush_i(flush_o),
    .issue_valid_i(issue_valid), .issue_op_i(issue_op),
    .issue_a_i(issue_a), .issue_b_i(issue_b), .issue_imm_i(issue_imm),
    .issue_pc_i(issue_pc), .issue_pnpc_i(issue_pnpc), .issue_tag_i(issue_tag),
    .wb_valid_o(wb_valid), .wb_tag_o(wb_tag),
    .wb_value_o(wb_value), .wb_npc_o(wb_npc)
  );

  // operands are read at the queue head
  reg_file #(.XLEN(XLEN)) u_regs (
    .clock, .arst_n_i,
    .raddr1_i(head_rs1), .raddr2_i(head_rs2),
    .rdata1_o(rdata1), .rdata2_o(rdata2),
    .we_i(commit_valid_o), .waddr_i(commit_rd_o), .wdata_i(commit_value_o)
  );

endmodule

`default_nettype wire

// File: rtl/issue_pkg.sv
`default_nettype none

package issue_pkg;

  // micro-op kinds seen by the issue logic
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    OP_ADDI = 4'h5,
    OP_BEQ  = 4'h6,
    OP_BNE  = 4'h7
  } opcode_e;

  // reorder buffer entry life cycle
  typedef enum logic [1:0] {
    ST_EMPTY = 2'b00,
    ST_EXEC  = 2'b01,
    ST_DONE  = 2'b10
  } rob_state_e;

  localparam int unsigned REG_NUM = 32;
  localparam int unsigned REG_W = 5;

  // sequential next-pc increment
  localparam int unsigned PC_STEP = 4;

endpackage

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file #(
  parameter int unsigned XLEN = 32
) (
  input  logic                        clock,
  input  logic                        arst_n_i,
  input  logic [issue_pkg::REG_W-1:0] raddr1_i,
  input  logic [issue_pkg::REG_W-1:0] raddr2_i,
  output logic [XLEN-1:0]             rdata1_o,
  output logic [XLEN-1:0]             rdata2_o,
  input  logic                        we_i,
  input  logic [issue_pkg::REG_W-1:0] waddr_i,
  input  logic [XLEN-1:0]             wdata_i
);
  logic [XLEN-1:0] regs [issue_pkg::REG_NUM];

  // x0 stays zero
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < issue_pkg::REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/reorder_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer #(
  parameter int unsigned XLEN = 32,
  parameter int unsigned ROB_DEPTH = 8
) (
  input  logic                         clock,
  input  logic                         arst_n_i,
  input  logic                         head_valid_i,
  input  issue_pkg::opcode_e           head_op_i,
  input  logic [issue_pkg::REG_W-1:0]  head_rd_i,
  input  logic [issue_pkg::REG_W-1:0]  head_rs1_i,
  input  logic [issue_pkg::REG_W-1:0]  head_rs2_i,
  input  logic [XLEN-1:0]              head_imm_i,
  input  logic [XLEN-1:0]              head_pc_i,
  input  logic [XLEN-1:0]              head_pnpc_i,
  output logic                         dispatch_o,
  input  logic [XLEN-1:0]              rdata1_i,
  input  logic [XLEN-1:0]              rdata2_i,
  output logic                         issue_valid_o,
  output issue_pkg::opcode_e           issue_op_o,
  output logic [XLEN-1:0]              issue_a_o,
  output logic [XLEN-1:0]              issue_b_o,
  output logic [XLEN-1:0]              issue_imm_o,
  output logic [XLEN-1:0]              issue_pc_o,
  output logic [XLEN-1:0]              issue_pnpc_o,
  output logic [$clog2(ROB_DEPTH)-1:0] issue_tag_o,
  input  logic                         wb_valid_i,
  input  logic [$clog2(ROB_DEPTH)-1:0] wb_tag_i,
  input  logic [XLEN-1:0]              wb_value_i,
  input  logic [XLEN-1:0]              wb_npc_i,
  output logic                         commit_valid_o,
  output logic [issue_pkg::REG_W-1:0]  commit_rd_o,
  output logic [XLEN-1:0]              commit_value_o,
  output logic [XLEN-1:0]              commit_pc_o,
  output logic                         flush_o,
  output logic [XLEN-1:0]              redirect_pc_o
);
  localparam int unsigned TAG_W = $clog2(ROB_DEPTH);

  issue_pkg::rob_state_e       rob_state [ROB_DEPTH];
  logic [issue_pkg::REG_W-1:0] rob_rd    [ROB_DEPTH];
  logic [XLEN-1:0]             rob_value [ROB_DEPTH];
  logic [XLEN-1:0]             rob_pc    [ROB_DEPTH];
  logic [XLEN-1:0]             rob_pnpc  [ROB_DEPTH];
  logic [XLEN-1:0]             rob_npc   [ROB_DEPTH];
  logic                        rob_br    [ROB_DEPTH];
  logic [TAG_W-1:0]            head_q;
  logic [TAG_W-1:0]            tail_q;

  // scoreboard: which entry will write each register
  logic [issue_pkg::REG_NUM-1:0] rf_busy;
  logic [TAG_W-1:0]              rf_owner [issue_pkg::REG_NUM];

  logic [TAG_W-1:0] rs1_tag;
  logic [TAG_W-1:0] rs2_tag;
  logic             rs1_fwd;
  logic             rs2_fwd;
  logic             rs1_wait;
  logic             rs2_wait;
  logic             mispredict;
  logic             keep_busy;

  assign rs1_tag  = rf_owner[head_rs1_i];
  assign rs2_tag  = rf_owner[head_rs2_i];
  assign rs1_fwd  = rf_busy[head_rs1_i] && rob_state[rs1_tag] == issue_pkg::ST_DONE;
  assign rs2_fwd  = rf_busy[head_rs2_i] && rob_state[rs2_tag] == issue_pkg::ST_DONE;
  assign rs1_wait = head_rs1_i != '0 && rf_busy[head_rs1_i] && !rs1_fwd;
  assign rs2_wait = head_rs2_i != '0 && rf_busy[head_rs2_i] && !rs2_fwd;

  assign dispatch_o = head_valid_i && rob_state[tail_q] == issue_pkg::ST_EMPTY &&
                      !rs1_wait && !rs2_wait && !flush_o;

  // x0, then a finished entry, then the register file
  assign issue_a_o = (head_rs1_i == '0) ? '0 : (rs1_fwd ? rob_value[rs1_tag] : rdata1_i);
  assign issue_b_o = (head_rs2_i == '0) ? '0 : (rs2_fwd ? rob_value[rs2_tag] : rdata2_i);

  assign issue_valid_o = dispatch_o;
  assign issue_op_o    = head_op_i;
  assign issue_imm_o   = head_imm_i;
  assign issue_pc_o    = head_pc_i;
  assign issue_pnpc_o  = head_pnpc_i;
  assign issue_tag_o   = tail_q;

  assign commit_valid_o = rob_state[head_q] == issue_pkg::ST_DONE && !flush_o;
  assign commit_rd_o    = rob_rd[head_q];
  assign commit_value_o = rob_value[head_q];
  assign commit_pc_o    = rob_pc[head_q];
  assign mispredict     = rob_br[head_q] && rob_npc[head_q] != rob_pnpc[head_q];

  // a younger dispatch to the same rd takes over the busy bit
  assign keep_busy = rf_owner[commit_rd_o] != head_q ||
                     (dispatch_o && head_rd_i == commit_rd_o);

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      rf_busy <= '0;
      flush_o <= 1'b0;
      for (int i = 0; i < ROB_DEPTH; i++) begin
        rob_state[i] <= issue_pkg::ST_EMPTY;
      end
    end else if (flush_o) begin
      head_q  <= '0;
      tail_q  <= '0;
      rf_busy <= '0;
      flush_o <= 1'b0;
      for (int i = 0; i < ROB_DEPTH; i++) begin
        rob_state[i] <= issue_pkg::ST_EMPTY;
      end
    end else begin
      if (wb_valid_i) begin
        rob_state[wb_tag_i] <= issue_pkg::ST_DONE;
      end
      flush_o <= commit_valid_o && mispredict;
      if (commit_valid_o) begin
        rob_state[head_q] <= issue_pkg::ST_EMPTY;
        head_q            <= head_q + 1'b1;
        if (commit_rd_o != '0 && !keep_busy) begin
          rf_busy[commit_rd_o] <= 1'b0;
        end
      end
      if (dispatch_o) begin
        rob_state[tail_q] <= issue_pkg::ST_EXEC;
        tail_q            <= tail_q + 1'b1;
        if (head_rd_i != '0) begin
          rf_busy[head_rd_i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (dispatch_o) begin
      rob_rd[tail_q]   <= head_rd_i;
      rob_pc[tail_q]   <= head_pc_i;
      rob_pnpc[tail_q] <= head_pnpc_i;
      rob_br[tail_q]   <= head_op_i == issue_pkg::OP_BEQ || head_op_i == issue_pkg::OP_BNE;
      if (head_rd_i != '0) begin
        rf_owner[head_rd_i] <= tail_q;
      end
    end
    if (wb_valid_i) begin
      rob_value[wb_tag_i] <= wb_value_i;
      rob_npc[wb_tag_i]   <= wb_npc_i;
    end
    // held through the flush cycle since commit is blocked then
    if (commit_valid_o) begin
      redirect_pc_o <= rob_npc[head_q];
    end
  end

endmodule

`default_nettype wire

// File: rtl/uop_queue.sv
`timescale 1ns/100ps
`default_nettype none

module uop_queue #(
  parameter int unsigned XLEN = 32,
  parameter int unsigned UOQ_DEPTH = 4
) (
  input  logic                        clock,
  input  logic                        arst_n_i,
  input  logic                        flush_i,
  input  logic                        push_i,
  input  issue_pkg::opcode_e          push_op_i,
  input  logic [issue_pkg::REG_W-1:0] push_rd_i,
  input  logic [issue_pkg::REG_W-1:0] push_rs1_i,
  input  logic [issue_pkg::REG_W-1:0] push_rs2_i,
  input  logic [XLEN-1:0]             push_imm_i,
  input  logic [XLEN-1:0]             push_pc_i,
  input  logic [XLEN-1:0]             push_pnpc_i,
  input  logic                        pop_i,
  output logic                        full_o,
  output logic                        head_valid_o,
  output issue_pkg::opcode_e          head_op_o,
  output logic [issue_pkg::REG_W-1:0] head_rd_o,
  output logic [issue_pkg::REG_W-1:0] head_rs1_o,
  output logic [issue_pkg::REG_W-1:0] head_rs2_o,
  output logic [XLEN-1:0]             head_imm_o,
  output logic [XLEN-1:0]             head_pc_o,
  output logic [XLEN-1:0]             head_pnpc_o
);
  localparam int unsigned PTR_W = $clog2(UOQ_DEPTH);

  logic [PTR_W-1:0]            wr_ptr;
  logic [PTR_W-1:0]            rd_ptr;
  logic [UOQ_DEPTH-1:0]        slot_valid;
  issue_pkg::opcode_e          q_op   [UOQ_DEPTH];
  logic [issue_pkg::REG_W-1:0] q_rd   [UOQ_DEPTH];
  logic [issue_pkg::REG_W-1:0] q_rs1  [UOQ_DEPTH];
  logic [issue_pkg::REG_W-1:0] q_rs2  [UOQ_DEPTH];
  logic [XLEN-1:0]             q_imm  [UOQ_DEPTH];
  logic [XLEN-1:0]             q_pc   [UOQ_DEPTH];
  logic [XLEN-1:0]             q_pnpc [UOQ_DEPTH];

  // full when the write slot still holds an undispatched entry
  assign full_o       = slot_valid[wr_ptr];
  assign head_valid_o = slot_valid[rd_ptr];
  assign head_op_o    = q_op[rd_ptr];
  assign head_rd_o    = q_rd[rd_ptr];
  assign head_rs1_o   = q_rs1[rd_ptr];
  assign head_rs2_o   = q_rs2[rd_ptr];
  assign head_imm_o   = q_imm[rd_ptr];
  assign head_pc_o    = q_pc[rd_ptr];
  assign head_pnpc_o  = q_pnpc[rd_ptr];

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      slot_valid <= '0;
    end else if (flush_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      slot_valid <= '0;
    end else begin
      if (pop_i) begin
        rd_ptr             <= rd_ptr + 1'b1;
        slot_valid[rd_ptr] <= 1'b0;
      end
      if (push_i && !full_o) begin
        wr_ptr             <= wr_ptr + 1'b1;
        slot_valid[wr_ptr] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push_i && !full_o) begin
      q_op[wr_ptr]   <= push_op_i;
      q_rd[wr_ptr]   <= push_rd_i;
      q_rs1[wr_ptr]  <= push_rs1_i;
      q_rs2[wr_ptr]  <= push_rs2_i;
      q_imm[wr_ptr]  <= push_imm_i;
      q_pc[wr_ptr]   <= push_pc_i;
      q_pnpc[wr_ptr] <= push_pnpc_i;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# compile and run the issue_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_issue_core -f vlog.f -o sim_issue_core
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_issue_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1

// File: sim/clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clock_gen #(
  parameter realtime PERIOD = 8ns,
  parameter int unsigned RESET_CYCLES = 5
) (
  output logic clock_o,
  output logic arst_n_o
);
  initial begin
    clock_o  = 1'b0;
    arst_n_o = 1'b0;
    forever #(PERIOD / 2) clock_o = ~clock_o;
  end

  // release just after an edge so the first active cycle is clean
  initial begin
    repeat (RESET_CYCLES) @(posedge clock_o);
    #1 arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/issue_checker.sv
`timescale 1ns/100ps
`default_nettype none

module issue_checker (
  input  logic        clock,
  input  logic        arst_n_i,
  input  logic        commit_valid_i,
  input  logic [4:0]  commit_rd_i,
  input  logic [31:0] commit_value_i,
  input  logic [31:0] commit_pc_i,
  input  logic        flush_i,
  input  logic [31:0] redirect_pc_i,
  output int          errors_o,
  output logic        done_o
);
  string       e_name[$];
  logic [31:0] e_val[$];
  logic [31:0] e_pc[$];
  logic [4:0]  e_rd[$];
  logic        e_resume[$];
  int          ptr = 0;
  int          n_exp = -1;
  logic        seen_flush = 1'b0;

  // only C and R lines are expected to commit
  initial begin
    int          fd;
    string       line;
    string       name;
    string       kind;
    logic [31:0] f[8];
    errors_o = 0;
    fd = $fopen("sim/issue_tests.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line[0] == "#") continue;
        if ($sscanf(line, "%s %h %h %h %h %h %h %h %h %s", name, f[0], f[1], f[2],
                    f[3], f[4], f[5], f[6], f[7], kind) != 10) continue;
        if (kind == "C" || kind == "R") begin
          e_name.push_back(name);
          e_val.push_back(f[7]);
          e_pc.push_back(f[5]);
          e_rd.push_back(f[1][4:0]);
          e_resume.push_back(kind == "R");
        end
      end
      $fclose(fd);
    end
    n_exp = e_name.size();
  end

  assign done_o = (n_exp >= 0) && (ptr == n_exp);

  always @(posedge clock) begin
    if (arst_n_i && flush_i) begin
      if (ptr >= n_exp || !e_resume[ptr]) begin
        $display("flush raised where no resume line was expected");
        errors_o++;
      end else if (redirect_pc_i !== e_pc[ptr]) begin
        $display("[ERROR] %s: expected redirect %h, actual %h",
                 e_name[ptr], e_pc[ptr], redirect_pc_i);
        errors_o++;
      end
      seen_flush <= 1'b1;
    end
    if (arst_n_i && commit_valid_i) begin
      if (ptr >= n_exp) begin
        $display("unexpected commit at pc %h after the expected stream", commit_pc_i);
        errors_o++;
      end else begin
        if (commit_pc_i !== e_pc[ptr]) begin
          $display("[ERROR] %s: expected pc %h, actual %h", e_name[ptr], e_pc[ptr], commit_pc_i);
          errors_o++;
        end
        if (commit_value_i !== e_val[ptr] || commit_rd_i !== e_rd[ptr]) begin
          $display("[ERROR] %s: expected value %h rd %0d, actual %h rd %0d", e_name[ptr],
                   e_val[ptr], e_rd[ptr], commit_value_i, commit_rd_i);
          errors_o++;
        end
        if (e_resume[ptr] && !seen_flush) begin
          $display("resume line %s committed without a flush before it", e_name[ptr]);
          errors_o++;
        end
        if (e_resume[ptr]) seen_flush <= 1'b0;
        ptr <= ptr + 1;
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/issue_core_properties.sv
`timescale 1ns/100ps
`default_nettype none

module issue_core_properties (
  input logic clock,
  input logic arst_n_i,
  input logic commit_valid_o,
  input logic flush_o
);
  a_flush_one_cycle: assert property (
    @(posedge clock) disable iff (!arst_n_i) flush_o |=> !flush_o
  ) else $error("flush_o held longer than one cycle");

  // flush empties the buffer, so nothing commits then or in the cycle after
  a_no_commit_in_flush: assert property (
    @(posedge clock) disable iff (!arst_n_i) (flush_o || $past(flush_o)) |-> !commit_valid_o
  ) else $error("commit during or right after a flush");

  // first sampled cycle out of reset
  a_quiet_after_reset: assert property (
    @(posedge clock) $rose(arst_n_i) |-> !commit_valid_o && !flush_o
  ) else $error("commit or flush right after reset");

endmodule

bind issue_core issue_core_properties issue_core_properties_i (.*);

`default_nettype wire

// File: sim/issue_tests.txt
# name op rd rs1 rs2 imm pc pnpc expected kind (all numbers hex)
# op: 0 add 1 sub 2 and 3 or 4 xor 5 addi 6 beq 7 bne; kind C commit, W wrong path, R resume
addi_a   5 1 0 0 00000010 00000000 00000004 00000010 C
addi_b   5 2 0 0 00000003 00000004 00000008 00000003 C
add_c    0 3 1 2 00000000 00000008 0000000c 00000013 C
sub_d    1 4 1 2 00000000 0000000c 00000010 0000000d C
and_e    2 5 3 4 00000000 00000010 00000014 00000001 C
or_f     3 6 3 4 00000000 00000014 00000018 0000001f C
xor_g    4 7 6 5 00000000 00000018 0000001c 0000001e C
addi_x0  5 0 1 0 00000007 0000001c 00000020 00000017 C
add_rdx0 0 8 0 1 00000000 00000020 00000024 00000010 C
beq_ok   6 0 1 8 00000008 00000024 0000002c 00000000 C
bne_miss 7 0 1 2 00000040 0000002c 00000030 00000000 C
wrong_a  5 9 0 0 00000055 00000030 00000034 00000055 W
wrong_b  0 a 9 9 00000000 00000034 00000038 000000aa W
resume_a 5 9 1 0 00000001 0000006c 00000070 00000011 R
chain_1  5 a 9 0 00000001 00000070 00000074 00000012 C
chain_2  5 a a 0 00000001 00000074 00000078 00000013 C
chain_3  0 a a a 00000000 00000078 0000007c 00000026 C
chain_4  5 a a 0 00000002 0000007c 00000080 00000028 C
chain_5  1 b a 9 00000000 00000080 00000084 00000017 C
chain_6  4 c b a 00000000 00000084 00000088 0000003f C
chain_7  0 d c c 00000000 00000088 0000008c 0000007e C
beq_miss 6 0 0 0 00000010 0000008c 00000090 00000000 C
wrong_c  5 e 0 0 00000009 00000090 00000094 00000009 W
resume_b 3 e d 1 00000000 0000009c 000000a0 0000007e R
final_f  5 f e 0 00000001 000000a0 000000a4 0000007f C

// File: sim/tb_issue_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_issue_core;
  logic               clock;
  logic               arst_n;
  logic               uop_valid;
  issue_pkg::opcode_e uop_op;
  logic [4:0]         uop_rd;
  logic [4:0]         uop_rs1;
  logic [4:0]         uop_rs2;
  logic [31:0]        uop_imm;
  logic [31:0]        uop_pc;
  logic [31:0]        uop_pnpc;
  logic               uop_ready;
  logic               commit_valid;
  logic [4:0]         commit_rd;
  logic [31:0]        commit_value;
  logic [31:0]        commit_pc;
  logic               flush;
  logic [31:0]        redirect_pc;
  int                 chk_errors;
  logic               chk_done;

  logic [3:0]  t_op[$];
  logic [4:0]  t_rd[$];
  logic [4:0]  t_rs1[$];
  logic [4:0]  t_rs2[$];
  logic [31:0] t_imm[$];
  logic [31:0] t_pc[$];
  logic [31:0] t_pnpc[$];
  string       t_kind[$];
  int          n_lines = 0;
  int          tb_errors = 0;
  int          full_cycles = 0;

  clock_gen #(.PERIOD(8ns), .RESET_CYCLES(5)) clock_gen_i (.clock_o(clock), .arst_n_o(arst_n));

  issue_core #(.XLEN(32), .UOQ_DEPTH(4), .ROB_DEPTH(8)) issue_core_i (
    .clock, .arst_n_i(arst_n),
    .uop_valid_i(uop_valid), .uop_op_i(uop_op), .uop_rd_i(uop_rd),
    .uop_rs1_i(uop_rs1), .uop_rs2_i(uop_rs2), .uop_imm_i(uop_imm),
    .uop_pc_i(uop_pc), .uop_pnpc_i(uop_pnpc), .uop_ready_o(uop_ready),
    .commit_valid_o(commit_valid), .commit_rd_o(commit_rd),
    .commit_value_o(commit_value), .commit_pc_o(commit_pc),
    .flush_o(flush), .redirect_pc_o(redirect_pc)
  );

  issue_checker issue_checker_i (
    .clock, .arst_n_i(arst_n),
    .commit_valid_i(commit_valid), .commit_rd_i(commit_rd),
    .commit_value_i(commit_value), .commit_pc_i(commit_pc),
    .flush_i(flush), .redirect_pc_i(redirect_pc),
    .errors_o(chk_errors), .done_o(chk_done)
  );

  task automatic load_tests();
    int          fd;
    string       line;
    string       name;
    string       kind;
    logic [31:0] f[8];
    fd = $fopen("sim/issue_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test file");
      tb_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      if ($sscanf(line, "%s %h %h %h %h %h %h %h %h %s", name, f[0], f[1], f[2],
                  f[3], f[4], f[5], f[6], f[7], kind) != 10) continue;
      t_op.push_back(f[0][3:0]);
      t_rd.push_back(f[1][4:0]);
      t_rs1.push_back(f[2][4:0]);
      t_rs2.push_back(f[3][4:0]);
      t_imm.push_back(f[4]);
      t_pc.push_back(f[5]);
      t_pnpc.push_back(f[6]);
      t_kind.push_back(kind);
    end
    $fclose(fd);
    n_lines = t_op.size();
  endtask

  function automatic int next_resume(int from);
    for (int j = from; j < n_lines; j++) begin
      if (t_kind[j] == "R") return j;
    end
    return n_lines;
  endfunction

  task automatic drive_line(int i);
    uop_valid = 1'b1;
    uop_op    = issue_pkg::opcode_e'(t_op[i]);
    uop_rd    = t_rd[i];
    uop_rs1   = t_rs1[i];
    uop_rs2   = t_rs2[i];
    uop_imm   = t_imm[i];
    uop_pc    = t_pc[i];
    uop_pnpc  = t_pnpc[i];
  endtask

  initial begin
    int   idx;
    int   r_ptr;
    logic burst;
    uop_valid = 1'b0;
    uop_op    = issue_pkg::OP_ADD;
    uop_rd    = '0;
    uop_rs1   = '0;
    uop_rs2   = '0;
    uop_imm   = '0;
    uop_pc    = '0;
    uop_pnpc  = '0;
    burst     = 1'b0;
    void'($urandom(91));
    load_tests();
    wait (arst_n === 1'b1);
    @(negedge clock);
    if (commit_valid !== 1'b0 || flush !== 1'b0 || uop_ready !== 1'b1) begin
      $display("outputs not in their reset state after reset");
      tb_errors++;
    end
    idx   = 0;
    r_ptr = next_resume(0);
    while (!chk_done) begin
      @(negedge clock);
      if (uop_valid && uop_ready) idx++;
      if (!uop_ready) full_cycles++;
      @(posedge clock);
      #1;
      if (flush) begin
        // resume at the target of the mispredicted branch
        idx       = r_ptr;
        r_ptr     = next_resume(r_ptr + 1);
        uop_valid = 1'b0;
        // back-to-back feeding behind the dependency chain
        burst     = 1'b1;
      end else if (idx < n_lines && (burst || ($urandom % 4) != 0)) begin
        drive_line(idx);
      end else begin
        uop_valid = 1'b0;
      end
    end
    uop_valid = 1'b0;
    repeat (20) @(posedge clock);
    if (full_cycles == 0) begin
      $display("the micro-op queue never filled up");
      tb_errors++;
    end
    $display("summary: %0d checker errors, %0d testbench errors", chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (n_lines > 0);
    repeat (40 * n_lines + 100) @(posedge clock);
    $display("timeout: the expected commits did not all arrive");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
rtl/issue_pkg.sv
rtl/uop_queue.sv
rtl/reorder_buffer.sv
rtl/alu_pipe.sv
rtl/reg_file.sv
rtl/issue_core.sv
sim/clock_gen.sv
sim/issue_checker.sv
sim/issue_core_properties.sv
sim/tb_issue_core.sv
